//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// address split of a word address: tag | index | offset
	localparam int addr_bits      = 32;
	localparam int word_bits      = 32;
	localparam int words_per_line = 4;
	localparam int offset_bits    = $clog2(words_per_line); // word inside line
	localparam int index_bits     = 4;
	localparam int num_sets       = 1 << index_bits;        // 16 sets
	localparam int tag_bits       = addr_bits - index_bits - offset_bits;
	localparam int line_bits      = word_bits * words_per_line;

	// controller states
	typedef enum logic [2:0] {
		idle,
		lookup,
		write_back,  // dirty victim goes out first
		refill,
		install,
		respond
	} cache_state_t;

	// request kind
	typedef enum logic {
		op_read,
		op_write
	} cache_op_t;

endpackage

`default_nettype wire

//--- verilog/burst_counter.sv
`timescale 1ns/1ps
`default_nettype none

module burst_counter import cache_pkg::*; (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    clear,
	input  wire                    en,
	input  wire                    mem_ready,
	output logic [offset_bits-1:0] beat,
	output logic                   last
);

	logic step;

	assign step = en && mem_ready; // one word completed

	// fourth beat of the burst, the counter wraps back to zero after it
	assign last = step && (beat == offset_bits'(words_per_line - 1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			beat <= '0;
		end else if (clear) begin
			beat <= '0;
		end else if (step) begin
			beat <= beat + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/cache_way_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way_store import cache_pkg::*; (
	input  wire                   clk,
	input  wire                   reset,
	input  wire  [index_bits-1:0] index,
	input  wire  [tag_bits-1:0]   line_tag,
	input  wire                   tag_we,
	input  wire                   data_we,
	input  wire                   fill_way,
	input  wire                   set_dirty,
	input  wire                   touch,
	input  wire  [line_bits-1:0]  wline,
	output logic                  hit,
	output logic                  hit_way,
	output logic                  victim_way,
	output logic                  victim_dirty,
	output logic [tag_bits-1:0]   victim_tag,
	output logic [line_bits-1:0]  rline
);

	logic [tag_bits-1:0]  tag_arr  [2][num_sets];
	logic [line_bits-1:0] data_arr [2][num_sets];
	logic [num_sets-1:0]  valid [2];
	logic [num_sets-1:0]  dirty [2];
	logic [num_sets-1:0]  repl;   // names the next victim way

	logic [tag_bits-1:0]  rtag  [2];
	logic [line_bits-1:0] rdata [2];
	logic [1:0]           rvalid;
	logic [1:0]           rdirty;
	logic                 rrepl;
	logic [1:0]           way_hit;

	// arrays, read one cycle after index
	always_ff @(posedge clk) begin
		if (tag_we)
			tag_arr[fill_way][index] <= line_tag;
		if (data_we)
			data_arr[fill_way][index] <= wline;
		for (int w = 0; w < 2; w++) begin
			rtag[w]  <= tag_arr[w][index];
			rdata[w] <= data_arr[w][index];
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid  <= '{default: '0};
			dirty  <= '{default: '0};
			repl   <= '0;
			rvalid <= '0;
			rdirty <= '0;
			rrepl  <= 1'b0;
		end else begin
			if (tag_we) begin
				valid[fill_way][index] <= 1'b1;
				dirty[fill_way][index] <= set_dirty; // fresh line
			end else if (data_we && set_dirty) begin
				dirty[fill_way][index] <= 1'b1;      // write hit
			end
			if (touch)
				repl[index] <= ~fill_way;            // other way goes next
			for (int w = 0; w < 2; w++) begin
				rvalid[w] <= valid[w][index];
				rdirty[w] <= dirty[w][index];
			end
			rrepl <= repl[index];
		end
	end

	assign way_hit[0] = rvalid[0] && (rtag[0] == line_tag);
	assign way_hit[1] = rvalid[1] && (rtag[1] == line_tag);
	assign hit        = |way_hit;
	assign hit_way    = way_hit[1];

	// empty way first, way 0 before way 1
	assign victim_way   = !rvalid[0] ? 1'b0 : (!rvalid[1] ? 1'b1 : rrepl);
	assign victim_dirty = rvalid[victim_way] && rdirty[victim_way];
	assign victim_tag   = rtag[victim_way];
	assign rline        = rdata[hit ? hit_way : victim_way];

endmodule

`default_nettype wire

//--- verilog/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer import cache_pkg::*; (
	input  wire                    clk,
	input  wire                    reset,
	input  wire  [line_bits-1:0]   rline,
	input  wire  [word_bits-1:0]   mem_rdata,
	input  wire  [word_bits-1:0]   wdata,
	input  wire  [offset_bits-1:0] offset,
	input  wire  [offset_bits-1:0] beat,
	input  wire  cache_op_t        op,
	input  wire                    load,
	input  wire                    shift,
	input  wire                    merge,
	output logic [line_bits-1:0]   wline,
	output logic [word_bits-1:0]   rdata_up,
	output logic [word_bits-1:0]   mem_wdata
);

	logic [words_per_line-1:0][word_bits-1:0] line_q;
	logic [words_per_line-1:0][word_bits-1:0] line_d;

	// later controls win, so a merge lands on top of the last refill word
	always_comb begin
		line_d = line_q;
		if (load)
			line_d = rline;                 // victim or hit line
		if (shift)
			line_d[beat] = mem_rdata;       // refill beat
		if (merge && op == op_write)
			line_d[offset] = wdata;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset)
			line_q <= '0;
		else
			line_q <= line_d;
	end

	assign wline     = line_q;
	assign rdata_up  = line_q[offset];
	assign mem_wdata = line_q[beat];       // write-back stream

endmodule

`default_nettype wire

//--- verilog/cache_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl_fsm import cache_pkg::*; (
	input  wire                    clk,
	input  wire                    reset,
	input  wire  [addr_bits-1:0]   addr_up,
	input  wire  [word_bits-1:0]   wdata_up,
	input  wire                    read_up,
	input  wire                    write_up,
	output logic                   ack_up,
	input  wire                    hit,
	input  wire                    hit_way,
	input  wire                    victim_way,
	input  wire                    victim_dirty,
	input  wire  [tag_bits-1:0]    victim_tag,
	input  wire  [offset_bits-1:0] beat,
	input  wire                    last,
	input  wire                    mem_ready,
	output logic [index_bits-1:0]  index,
	output logic [tag_bits-1:0]    line_tag,
	output logic [offset_bits-1:0] offset,
	output cache_op_t              op,
	output logic [word_bits-1:0]   wdata,
	output logic                   tag_we,
	output logic                   data_we,
	output logic                   fill_way,
	output logic                   set_dirty,
	output logic                   touch,
	output logic                   buf_load,
	output logic                   buf_shift,
	output logic                   buf_merge,
	output logic                   cnt_clear,
	output logic                   cnt_en,
	output logic [addr_bits-1:0]   mem_addr,
	output logic                   mem_read,
	output logic                   mem_write
);

	cache_state_t         state, state_nx;
	cache_op_t            op_q;
	logic [addr_bits-1:0] addr_q;
	logic [word_bits-1:0] wdata_q;
	logic                 hit_q;  // request took the hit path
	logic                 way_q;  // way being served or filled

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= idle;
			op_q  <= op_read;
			hit_q <= 1'b0;
			way_q <= 1'b0;
		end else begin
			state <= state_nx;
			if (state == idle && (read_up || write_up))
				op_q <= write_up ? op_write : op_read;
			if (state == lookup) begin
				hit_q <= hit;
				way_q <= hit ? hit_way : victim_way;
			end
		end
	end

	// request payload
	always_ff @(posedge clk) begin
		if (state == idle) begin
			addr_q  <= addr_up;
			wdata_q <= wdata_up;
		end
	end

	// in idle the store already sees the incoming index
	assign index    = (state == idle) ? addr_up[offset_bits +: index_bits]
	                                  : addr_q[offset_bits +: index_bits];
	assign line_tag = addr_q[addr_bits-1 -: tag_bits];
	assign offset   = addr_q[offset_bits-1:0];
	assign op       = op_q;
	assign wdata    = wdata_q;
	assign fill_way = way_q;

	// burst address, victim line during write-back
	assign mem_addr = {(state == write_back) ? victim_tag : line_tag,
	                   addr_q[offset_bits +: index_bits], beat};

	always_comb begin
		state_nx  = state;
		ack_up    = 1'b0;
		tag_we    = 1'b0;
		data_we   = 1'b0;
		set_dirty = 1'b0;
		touch     = 1'b0;
		buf_load  = 1'b0;
		buf_shift = 1'b0;
		buf_merge = 1'b0;
		cnt_clear = 1'b0;
		cnt_en    = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		case (state)
			idle: begin
				if (read_up || write_up)
					state_nx = lookup;
			end
			lookup: begin
				buf_load = 1'b1;          // hit line, or victim for write-back
				if (hit) begin
					buf_merge = 1'b1;     // write hit merges right away
					state_nx  = respond;
				end else begin
					cnt_clear = 1'b1;
					state_nx  = victim_dirty ? write_back : refill;
				end
			end
			write_back: begin
				mem_write = 1'b1;
				cnt_en    = 1'b1;
				if (last)
					state_nx = refill;
			end
			refill: begin
				mem_read  = 1'b1;
				cnt_en    = 1'b1;
				buf_shift = mem_ready;
				if (last) begin
					buf_merge = 1'b1;
					state_nx  = install;
				end
			end
			install: begin
				tag_we    = 1'b1;
				data_we   = 1'b1;
				set_dirty = (op_q == op_write);
				state_nx  = respond;
			end
			respond: begin
				ack_up    = 1'b1;
				touch     = 1'b1;
				data_we   = hit_q && (op_q == op_write); // merged hit line back
				set_dirty = hit_q && (op_q == op_write);
				state_nx  = idle;
			end
			default: state_nx = idle;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_pkg::*; (
	input  wire                  clk,
	input  wire                  reset,
	input  wire  [addr_bits-1:0] addr_up,
	input  wire  [word_bits-1:0] wdata_up,
	input  wire                  read_up,
	input  wire                  write_up,
	output logic [word_bits-1:0] rdata_up,
	output logic                 ack_up,
	input  wire  [word_bits-1:0] mem_rdata,
	input  wire                  mem_ready,
	output logic [addr_bits-1:0] mem_addr,
	output logic [word_bits-1:0] mem_wdata,
	output logic                 mem_read,
	output logic                 mem_write
);

	logic                   hit, hit_way, victim_way, victim_dirty;
	logic [tag_bits-1:0]    victim_tag;
	logic [line_bits-1:0]   rline, wline;
	logic [offset_bits-1:0] beat, offset;
	logic                   last;
	logic [index_bits-1:0]  index;
	logic [tag_bits-1:0]    line_tag;
	cache_op_t              op;
	logic [word_bits-1:0]   wdata;
	logic                   tag_we, data_we, fill_way, set_dirty, touch;
	logic                   buf_load, buf_shift, buf_merge;
	logic                   cnt_clear, cnt_en;

	cache_ctrl_fsm cache_ctrl_fsm_inst (
		.clk, .reset,
		.addr_up, .wdata_up, .read_up, .write_up, .ack_up,
		.hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.beat, .last, .mem_ready,
		.index, .line_tag, .offset, .op, .wdata,
		.tag_we, .data_we, .fill_way, .set_dirty, .touch,
		.buf_load, .buf_shift, .buf_merge,
		.cnt_clear, .cnt_en,
		.mem_addr, .mem_read, .mem_write
	);

	burst_counter burst_counter_inst (
		.clk, .reset,
		.clear (cnt_clear),
		.en    (cnt_en),
		.mem_ready,
		.beat, .last
	);

	cache_way_store cache_way_store_inst (
		.clk, .reset,
		.index, .line_tag,
		.tag_we, .data_we, .fill_way, .set_dirty, .touch,
		.wline,
		.hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.rline
	);

	line_buffer line_buffer_inst (
		.clk, .reset,
		.rline, .mem_rdata, .wdata,
		.offset, .beat, .op,
		.load  (buf_load),
		.shift (buf_shift),
		.merge (buf_merge),
		.wline, .rdata_up, .mem_wdata
	);

endmodule

`default_nettype wire

//--- tb/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
	parameter int period       = 40,
	parameter int reset_cycles = 8
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// active low, released on a rising edge
	initial begin
		reset = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b1;
	end

endmodule

`default_nettype wire

//--- tb/cache_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cache_assert import cache_pkg::*; #(
	parameter logic [word_bits-1:0] pattern = '0
) (
	input wire                 clk,
	input wire                 reset,
	input wire [addr_bits-1:0] addr_up,
	input wire [word_bits-1:0] wdata_up,
	input wire                 read_up,
	input wire                 write_up,
	input wire [word_bits-1:0] rdata_up,
	input wire                 ack_up,
	input wire                 mem_ready,
	input wire [addr_bits-1:0] mem_addr,
	input wire [word_bits-1:0] mem_wdata,
	input wire                 mem_read,
	input wire                 mem_write
);

	localparam int shadow_words = 1024;

	int error_count = 0;

	// expected set contents, updated when a request completes
	logic [tag_bits-1:0]  m_tag [2][num_sets];
	logic [num_sets-1:0]  m_valid [2];
	logic [num_sets-1:0]  m_dirty [2];
	logic [num_sets-1:0]  m_repl;
	logic [shadow_words-1:0] shadow_valid;   // words written by the processor
	logic [word_bits-1:0]    shadow_data [shadow_words];

	logic [index_bits-1:0] set_i;
	logic [tag_bits-1:0]   tag_i;
	logic                  hit0, hit1, exp_hit, exp_way, exp_wb;
	logic                  busy, seen_req, req_start, miss_q, wb_q, quiet_mem;
	logic [addr_bits-offset_bits-1:0] wb_line, wb_line_q;
	logic [2:0]            rd_beats, wr_beats;    // completed beats of this request
	logic [word_bits-1:0]  exp_rdata, exp_wdata;
	logic [addr_bits-1:0]  exp_rd_addr, exp_wb_addr;

	assign set_i   = addr_up[offset_bits +: index_bits];
	assign tag_i   = addr_up[addr_bits-1 -: tag_bits];
	assign hit0    = m_valid[0][set_i] && (m_tag[0][set_i] == tag_i);
	assign hit1    = m_valid[1][set_i] && (m_tag[1][set_i] == tag_i);
	assign exp_hit = hit0 || hit1;
	// hit way, else first empty way, else the replacement bit
	assign exp_way = hit0 ? 1'b0 : hit1 ? 1'b1 :
	                 !m_valid[0][set_i] ? 1'b0 : !m_valid[1][set_i] ? 1'b1 : m_repl[set_i];
	assign exp_wb  = !exp_hit && m_valid[exp_way][set_i] && m_dirty[exp_way][set_i];
	assign wb_line = {m_tag[exp_way][set_i], set_i};

	assign req_start = (read_up || write_up) && !busy;
	assign quiet_mem = !mem_read && !mem_write;

	assign exp_rdata   = shadow_valid[addr_up[9:0]] ? shadow_data[addr_up[9:0]]
	                                                : addr_up ^ pattern;
	assign exp_wdata   = shadow_valid[mem_addr[9:0]] ? shadow_data[mem_addr[9:0]]
	                                                 : mem_addr ^ pattern;
	assign exp_rd_addr = {addr_up[addr_bits-1:offset_bits], rd_beats[offset_bits-1:0]};
	assign exp_wb_addr = {wb_line_q, wr_beats[offset_bits-1:0]};

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			m_valid      <= '{default: '0};
			m_dirty      <= '{default: '0};
			m_repl       <= '0;
			shadow_valid <= '0;
			busy         <= 1'b0;
			seen_req     <= 1'b0;
			miss_q       <= 1'b0;
			wb_q         <= 1'b0;
			rd_beats     <= '0;
			wr_beats     <= '0;
		end else begin
			if (req_start) begin
				busy      <= 1'b1;
				seen_req  <= 1'b1;
				miss_q    <= !exp_hit;
				wb_q      <= exp_wb;
				wb_line_q <= wb_line;
				rd_beats  <= '0;
				wr_beats  <= '0;
			end
			if (mem_read && mem_ready)
				rd_beats <= rd_beats + 1'b1;
			if (mem_write && mem_ready)
				wr_beats <= wr_beats + 1'b1;
			if (ack_up) begin
				busy                    <= 1'b0;
				m_tag[exp_way][set_i]   <= tag_i;
				m_valid[exp_way][set_i] <= 1'b1;
				m_dirty[exp_way][set_i] <= write_up || (exp_hit && m_dirty[exp_way][set_i]);
				m_repl[set_i]           <= ~exp_way; // other way goes next
				if (write_up) begin
					shadow_valid[addr_up[9:0]] <= 1'b1;
					shadow_data[addr_up[9:0]]  <= wdata_up;
				end
			end
		end
	end

	quiet_after_reset: assert property (@(posedge clk) disable iff (!reset)
		!seen_req |-> !ack_up && quiet_mem)
	else begin
		$error("ack_up or a memory request came before the first request");
		error_count++;
	end

	hit_latency: assert property (@(posedge clk) disable iff (!reset)
		req_start && exp_hit |-> (!ack_up && quiet_mem) ##1 (!ack_up && quiet_mem)
			##1 (ack_up && quiet_mem))
	else begin
		$error("hit at address %h not answered two cycles later without memory traffic",
			$sampled(addr_up));
		error_count++;
	end

	ack_pulse: assert property (@(posedge clk) disable iff (!reset) ack_up |=> !ack_up)
	else begin
		$error("ack_up stayed high for more than one cycle");
		error_count++;
	end

	refill_beats: assert property (@(posedge clk) disable iff (!reset)
		ack_up && miss_q |-> rd_beats == 3'd4)
	else begin
		$error("FAIL %0t refill beats expected 4 got %0d", $time, $sampled(rd_beats));
		error_count++;
	end

	write_back_beats: assert property (@(posedge clk) disable iff (!reset)
		ack_up |-> wr_beats == (wb_q ? 3'd4 : 3'd0))
	else begin
		$error("FAIL %0t write-back beats expected %0d got %0d", $time,
			$sampled(wb_q) ? 4 : 0, $sampled(wr_beats));
		error_count++;
	end

	refill_addr: assert property (@(posedge clk) disable iff (!reset)
		mem_read |-> mem_addr == exp_rd_addr)
	else begin
		$error("FAIL %0t mem_addr expected %h got %h", $time,
			$sampled(exp_rd_addr), $sampled(mem_addr));
		error_count++;
	end

	write_back_addr: assert property (@(posedge clk) disable iff (!reset)
		mem_write |-> mem_addr == exp_wb_addr)
	else begin
		$error("FAIL %0t mem_addr expected %h got %h", $time,
			$sampled(exp_wb_addr), $sampled(mem_addr));
		error_count++;
	end

	write_back_first: assert property (@(posedge clk) disable iff (!reset)
		mem_write |-> rd_beats == 3'd0)
	else begin
		$error("write-back burst started after the refill had begun");
		error_count++;
	end

	write_back_data: assert property (@(posedge clk) disable iff (!reset)
		mem_write && mem_ready |-> mem_wdata == exp_wdata)
	else begin
		$error("FAIL %0t mem_wdata expected %h got %h", $time,
			$sampled(exp_wdata), $sampled(mem_wdata));
		error_count++;
	end

	read_data: assert property (@(posedge clk) disable iff (!reset)
		ack_up && read_up |-> rdata_up == exp_rdata)
	else begin
		$error("FAIL %0t rdata_up expected %h got %h", $time,
			$sampled(exp_rdata), $sampled(rdata_up));
		error_count++;
	end

endmodule

`default_nettype wire

//--- tb/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_pkg::*; ;

	localparam logic [word_bits-1:0] mem_pattern = 32'h3C5A_96E1;
	localparam int mem_words      = 1024;
	localparam int timeout_cycles = 300;

	// set 1 for the single-line tests, sets 4 and 5 for eviction
	localparam logic [addr_bits-1:0] addr_d = 32'h0000_0104;
	localparam logic [addr_bits-1:0] addr_a = 32'h0000_0011;
	localparam logic [addr_bits-1:0] addr_b = 32'h0000_0051;
	localparam logic [addr_bits-1:0] addr_c = 32'h0000_0091;
	localparam logic [addr_bits-1:0] addr_e = 32'h0000_0014;
	localparam logic [addr_bits-1:0] addr_f = 32'h0000_0054;
	localparam logic [addr_bits-1:0] addr_g = 32'h0000_0094;

	logic                 clk, reset;
	logic [addr_bits-1:0] addr_up, mem_addr;
	logic [word_bits-1:0] wdata_up, rdata_up, mem_rdata, mem_wdata;
	logic                 read_up, write_up, ack_up;
	logic                 mem_ready, mem_read, mem_write;

	logic [word_bits-1:0] mem_data [mem_words];
	logic [mem_words-1:0] mem_written;
	int                   passed, failed;
	bit                   test_timeout;

	clock_gen #(.period(40), .reset_cycles(8)) clock_gen_inst (.clk, .reset);

	cache_top cache_top_inst (.*);

	// expected-data pattern matches mem_pattern
	bind cache_top cache_assert #(.pattern(32'h3C5A_96E1)) cache_assert_inst (.*);

	// unwritten words read as address ^ pattern
	assign mem_rdata = mem_written[mem_addr[9:0]] ? mem_data[mem_addr[9:0]]
	                                              : mem_addr ^ mem_pattern;

	always @(posedge clk) begin
		if (mem_write && mem_ready) begin
			mem_data[mem_addr[9:0]]    <= mem_wdata;
			mem_written[mem_addr[9:0]] <= 1'b1;
		end
	end

	initial begin
		mem_ready = 1'b0;
		void'($urandom(52));
		forever begin
			@(posedge clk);
			mem_ready <= ($urandom % 4) != 0; // ready about three beats in four
		end
	end

	function automatic int assertion_errors();
		return cache_top_inst.cache_assert_inst.error_count;
	endfunction

	task automatic cpu_access(input bit is_write, input logic [addr_bits-1:0] a,
	                          input logic [word_bits-1:0] d);
		int waited;
		waited = 0;
		@(posedge clk);
		addr_up  <= a;
		wdata_up <= d;
		read_up  <= !is_write;
		write_up <= is_write;
		forever begin
			@(negedge clk);
			if (ack_up)
				break;
			waited++;
			if (waited >= timeout_cycles) begin
				$display("timeout: no ack_up for the %s at address %h",
					is_write ? "write" : "read", a);
				test_timeout = 1'b1;
				break;
			end
		end
		@(posedge clk);
		read_up  <= 1'b0;
		write_up <= 1'b0;
	endtask

	task automatic report_test(input string name, input int errs_before);
		@(negedge clk); // assertions of the last edge have fired by now
		if (test_timeout || assertion_errors() != errs_before) begin
			failed++;
			$display("test %-24s failed", name);
		end else begin
			passed++;
			$display("test %-24s ok", name);
		end
		test_timeout = 1'b0;
	endtask

	initial begin
		int errs0;
		int waited;
		addr_up      = '0;
		wdata_up     = '0;
		read_up      = 1'b0;
		write_up     = 1'b0;
		mem_written  = '0;
		passed       = 0;
		failed       = 0;
		test_timeout = 1'b0;

		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (reset !== 1'b1 && waited < 50);
		if (reset !== 1'b1) begin
			$display("reset was never released");
			failed++;
		end

		errs0 = assertion_errors();
		repeat (6) @(posedge clk); // idle, nothing may move
		report_test("quiet after reset", errs0);

		errs0 = assertion_errors();
		cpu_access(1'b0, addr_d, '0);
		report_test("read miss", errs0);

		errs0 = assertion_errors();
		cpu_access(1'b0, addr_d + 2, '0);
		report_test("read hit same line", errs0);

		errs0 = assertion_errors();
		cpu_access(1'b1, addr_d + 1, 32'hDEAD_BEEF);
		cpu_access(1'b0, addr_d + 1, '0);
		report_test("write hit then read", errs0);

		// A dirty, B fills the other way, C evicts A
		errs0 = assertion_errors();
		cpu_access(1'b1, addr_a, 32'hA5A5_0011);
		cpu_access(1'b0, addr_b, '0);
		cpu_access(1'b0, addr_c, '0);
		cpu_access(1'b0, addr_a, '0);
		report_test("dirty eviction", errs0);

		errs0 = assertion_errors();
		cpu_access(1'b0, addr_e, '0);
		cpu_access(1'b0, addr_f, '0);
		cpu_access(1'b0, addr_e, '0);
		cpu_access(1'b0, addr_g, '0);  // should evict F
		cpu_access(1'b0, addr_e, '0);
		report_test("replacement order", errs0);

		$display("tests passed %0d, failed %0d, assertion errors %0d",
			passed, failed, assertion_errors());
		if (failed == 0 && assertion_errors() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
verilog/cache_pkg.sv
verilog/burst_counter.sv
verilog/cache_way_store.sv
verilog/line_buffer.sv
verilog/cache_ctrl_fsm.sv
verilog/cache_top.sv
tb/clock_gen.sv
tb/cache_assert.sv
tb/cache_tb.sv

//--- Bender.yml
package:
  name: cache_ctrl

sources:
  - verilog/cache_pkg.sv
  - verilog/burst_counter.sv
  - verilog/cache_way_store.sv
  - verilog/line_buffer.sv
  - verilog/cache_ctrl_fsm.sv
  - verilog/cache_top.sv
  - target: simulation
    files:
      - tb/clock_gen.sv
      - tb/cache_assert.sv
      - tb/cache_tb.sv
